//--- switch_cfg_pkg.sv
// Sizing constants for ports, data width, select width and queue depth
package switch_cfg_pkg;

    // Ingress and egress port count
    localparam int N_PORTS = 4;

    // Bits needed to name one real port
    localparam int PORT_W = $clog2(N_PORTS);

    // Data byte carried by every flit
    localparam int DATA_W = 8;

    // Select codes run from 0 to N_PORTS and the top code marks an idle output
    localparam int SEL_W = $clog2(N_PORTS + 1);
    localparam int IDLE_SEL = N_PORTS;

    // Ingress queue sizing
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

endpackage

//--- switch_types_pkg.sv
// Flit field, select map and word bus types shared by queues, scheduler and crossbar
package switch_types_pkg;

    import switch_cfg_pkg::*;

    // Destination field of a flit that is wide enough for real ports only
    typedef logic [PORT_W-1:0] dest_t;

    // One source-select value where IDLE_SEL means no source
    typedef logic [SEL_W-1:0] sel_t;

    // One select slot per output
    typedef sel_t [N_PORTS-1:0] sel_map_t;

    // One data word per port
    typedef logic [N_PORTS-1:0][DATA_W-1:0] word_bus_t;

endpackage

//--- ingress_fifo.sv
// Per-port flit queue with valid/ready push side and head/pop side
`timescale 1ns/1ps

module ingress_fifo (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              push_valid,
    output logic                              push_ready,
    input  switch_types_pkg::dest_t           push_dest,
    input  logic [switch_cfg_pkg::DATA_W-1:0] push_data,
    output logic                              head_valid,
    output switch_types_pkg::dest_t           head_dest,
    output logic [switch_cfg_pkg::DATA_W-1:0] head_data,
    input  logic                              pop
);
    import switch_cfg_pkg::*;
    import switch_types_pkg::*;

    dest_t                 dest_mem [FIFO_DEPTH];
    logic [DATA_W-1:0]     data_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    // Circular pointer step
    function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] p);
        if (p == FIFO_PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign push_ready = (count != FIFO_CNT_W'(FIFO_DEPTH));
    assign head_valid = (count != '0);
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop && head_valid;

    // Oldest flit is visible without delay
    assign head_dest = dest_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            dest_mem[wr_ptr] <= push_dest;
            data_mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leaves the count alone
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- output_arbiter.sv
// Per-output round-robin scheduler building the crossbar select map and queue pops
`timescale 1ns/1ps

module output_arbiter (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [switch_cfg_pkg::N_PORTS-1:0]                   head_valid,
    input  switch_types_pkg::dest_t [switch_cfg_pkg::N_PORTS-1:0] head_dest,
    output logic [switch_cfg_pkg::N_PORTS-1:0]                   pop,
    output switch_types_pkg::sel_map_t                           sel_map,
    output logic                                                 xbar_valid,
    input  logic                                                 xbar_ready
);
    import switch_cfg_pkg::*;
    import switch_types_pkg::*;

    // Search start point per output
    logic [PORT_W-1:0]  rr_ptr   [N_PORTS];
    logic [PORT_W-1:0]  next_ptr [N_PORTS];
    logic [N_PORTS-1:0] out_grant;

    // Each input has one head, so it asks for at most one output and
    // the per-output searches never grant the same input twice
    always_comb begin
        int idx;
        pop       = '0;
        out_grant = '0;
        for (int o = 0; o < N_PORTS; o++) begin
            sel_map[o]  = sel_t'(IDLE_SEL);
            next_ptr[o] = rr_ptr[o];
            for (int k = 0; k < N_PORTS; k++) begin
                idx = (int'(rr_ptr[o]) + k) % N_PORTS;
                // Nothing is granted while the crossbar is stalled
                if (xbar_ready && !out_grant[o] && head_valid[idx] &&
                    head_dest[idx] == dest_t'(o)) begin
                    out_grant[o] = 1'b1;
                    sel_map[o]   = sel_t'(idx);
                    pop[idx]     = 1'b1;
                    next_ptr[o]  = PORT_W'((idx + 1) % N_PORTS);
                end
            end
        end
    end

    assign xbar_valid = |out_grant;

    // Pointer moves past the winner only when its grant is taken
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int o = 0; o < N_PORTS; o++) begin
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < N_PORTS; o++) begin
                if (out_grant[o]) begin
                    rr_ptr[o] <= next_ptr[o];
                end
            end
        end
    end

endmodule

//--- crossbar_pipe.sv
// Two-stage crossbar registering the select map and words, then routing words to outputs
`timescale 1ns/1ps

module crossbar_pipe (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               valid_in,
    output logic                               ready_out,
    input  switch_types_pkg::sel_map_t         sel,
    input  switch_types_pkg::word_bus_t        din,
    output switch_types_pkg::word_bus_t        dout,
    output logic [switch_cfg_pkg::N_PORTS-1:0] mask,
    output logic                               valid_out,
    input  logic                               ready_in
);
    import switch_cfg_pkg::*;
    import switch_types_pkg::*;

    sel_map_t           sel_s1;
    word_bus_t          din_s1;
    logic [N_PORTS-1:0] sel_ok_s1;
    logic               valid_s1;

    word_bus_t          dout_s2;
    logic [N_PORTS-1:0] mask_s2;
    logic               valid_s2;

    // Whole pipe holds while a result waits at the egress
    logic stall;

    assign stall     = valid_s2 && !ready_in;
    assign ready_out = !stall;

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            sel_s1 <= sel;
            din_s1 <= din;
        end
    end

    // Stage 1 control marks an output live when its select names a real port
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            sel_ok_s1 <= '0;
        end else if (!stall) begin
            valid_s1 <= valid_in;
            for (int i = 0; i < N_PORTS; i++) begin
                sel_ok_s1[i] <= valid_in && (sel[i] < sel_t'(N_PORTS));
            end
        end
    end

    // Stage 2 routes the chosen word and zeroes idle outputs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_s2  <= '0;
            mask_s2  <= '0;
            valid_s2 <= 1'b0;
        end else if (!stall) begin
            valid_s2 <= valid_s1;
            mask_s2  <= sel_ok_s1;
            for (int i = 0; i < N_PORTS; i++) begin
                dout_s2[i] <= sel_ok_s1[i] ? din_s1[sel_s1[i][PORT_W-1:0]] : '0;
            end
        end
    end

    assign dout      = dout_s2;
    assign mask      = mask_s2;
    assign valid_out = valid_s2;

endmodule

//--- switch_top.sv
// Four-port switch top with ingress queues, output arbiter and crossbar
`timescale 1ns/1ps

module switch_top (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic [switch_cfg_pkg::N_PORTS-1:0]                   in_valid,
    output logic [switch_cfg_pkg::N_PORTS-1:0]                   in_ready,
    input  switch_types_pkg::dest_t [switch_cfg_pkg::N_PORTS-1:0] in_dest,
    input  switch_types_pkg::word_bus_t                          in_data,
    output logic                                                 out_valid,
    input  logic                                                 out_ready,
    output logic [switch_cfg_pkg::N_PORTS-1:0]                   out_mask,
    output switch_types_pkg::word_bus_t                          out_data
);
    import switch_cfg_pkg::*;
    import switch_types_pkg::*;

    // Queue heads seen by the arbiter and the crossbar
    logic [N_PORTS-1:0]       head_valid;
    dest_t [N_PORTS-1:0]      head_dest;
    word_bus_t                head_data;
    logic [N_PORTS-1:0]       pop;

    sel_map_t sel_map;
    logic     xbar_valid;
    logic     xbar_ready;

    for (genvar p = 0; p < N_PORTS; p++) begin : g_ingress
        ingress_fifo u_fifo (
            .clk        (clk),
            .rst_n      (rst_n),
            .push_valid (in_valid[p]),
            .push_ready (in_ready[p]),
            .push_dest  (in_dest[p]),
            .push_data  (in_data[p]),
            .head_valid (head_valid[p]),
            .head_dest  (head_dest[p]),
            .head_data  (head_data[p]),
            .pop        (pop[p])
        );
    end

    output_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .head_dest  (head_dest),
        .pop        (pop),
        .sel_map    (sel_map),
        .xbar_valid (xbar_valid),
        .xbar_ready (xbar_ready)
    );

    crossbar_pipe u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (xbar_valid),
        .ready_out (xbar_ready),
        .sel       (sel_map),
        .din       (head_data),
        .dout      (out_data),
        .mask      (out_mask),
        .valid_out (out_valid),
        .ready_in  (out_ready)
    );

endmodule

//--- tb_switch.sv
// Testbench for the four-port switch with pattern-file stimulus and per-pair delivery model
`timescale 1ns/1ps

module tb_switch;
    import switch_cfg_pkg::*;
    import switch_types_pkg::*;

    localparam int MAX_LINES    = 64;
    localparam int RESET_CYCLES = 10;
    // Egress is held low over this cycle window
    localparam int HOLD_START   = 35;
    localparam int HOLD_END     = 75;
    // Cycles allowed for the last queued flits to leave
    localparam int DRAIN_LIMIT  = 20 * N_PORTS * FIFO_DEPTH;

    logic                 clk;
    logic                 rst_n;
    logic [N_PORTS-1:0]   in_valid;
    logic [N_PORTS-1:0]   in_ready;
    dest_t [N_PORTS-1:0]  in_dest;
    word_bus_t            in_data;
    logic                 out_valid;
    logic                 out_ready;
    logic [N_PORTS-1:0]   out_mask;
    word_bus_t            out_data;

    int                n_lines;
    int                pat_dest [MAX_LINES];
    int                pat_data [MAX_LINES];
    int                pat_gap  [MAX_LINES];
    int                line_q   [N_PORTS][$];
    // One expected queue per source and destination pair
    logic [DATA_W-1:0] exp_q    [N_PORTS*N_PORTS][$];
    bit                loaded;
    bit                running;
    int                cyc;
    int                drain_cyc;
    bit                vld      [N_PORTS];
    int                wait_cnt [N_PORTS];
    int                hold_push[N_PORTS];
    bit                ready_dropped;
    logic              prev_valid;
    logic              prev_ready;
    logic [N_PORTS-1:0] prev_mask;
    word_bus_t         prev_data;
    int                last_rr_src;
    bit                other_busy;

    switch_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_dest   (in_dest),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_mask  (out_mask),
        .out_data  (out_data)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    p;
        int    d;
        int    v;
        int    g;
        string line;
        fd = $fopen("switch_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("Could not open the pattern file");
            stop_run();
        end
        n_lines = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %h %d", p, d, v, g);
                if (n == 4) begin
                    pat_dest[n_lines] = d;
                    pat_data[n_lines] = v;
                    pat_gap[n_lines]  = g;
                    line_q[p].push_back(n_lines);
                    n_lines++;
                end
            end
        end
        $fclose(fd);
    endtask

    function automatic bit all_sent();
        for (int p = 0; p < N_PORTS; p++) begin
            if (line_q[p].size() != 0 || vld[p]) begin
                return 0;
            end
        end
        return 1;
    endfunction

    function automatic int pending_total();
        int sum;
        sum = 0;
        for (int q = 0; q < N_PORTS*N_PORTS; q++) begin
            sum += exp_q[q].size();
        end
        return sum;
    endfunction

    task automatic drive_ports(input bit hold);
        int li;
        for (int p = 0; p < N_PORTS; p++) begin
            if (vld[p] && in_ready[p]) begin
                li = line_q[p][0];
                exp_q[p*N_PORTS + pat_dest[li]].push_back(DATA_W'(pat_data[li]));
                wait_cnt[p] = pat_gap[li];
                void'(line_q[p].pop_front());
                vld[p] = 0;
                if (hold) begin
                    hold_push[p]++;
                end
            end
            // At most two grants slip into the crossbar before it stalls
            if (hold) begin
                assert (hold_push[p] <= FIFO_DEPTH + 2) else begin
                    $display("Port %0d accepted %0d flits while egress was held", p, hold_push[p]);
                    stop_run();
                end
                if (!in_ready[p]) begin
                    ready_dropped = 1;
                end
            end
            if (!vld[p] && line_q[p].size() > 0) begin
                if (wait_cnt[p] > 0) begin
                    wait_cnt[p]--;
                end else begin
                    vld[p] = 1;
                end
            end
            in_valid[p] <= vld[p];
            if (vld[p]) begin
                in_dest[p] <= dest_t'(pat_dest[line_q[p][0]]);
                in_data[p] <= DATA_W'(pat_data[line_q[p][0]]);
            end
        end
    endtask

    task automatic check_egress();
        int src;
        int q;
        if (prev_valid && !prev_ready) begin
            assert (out_valid) else begin
                $display("[FAIL] out_valid got %h expected 1 during stall", out_valid);
                stop_run();
            end
            assert (out_mask == prev_mask) else begin
                $display("[FAIL] out_mask got %h expected %h", out_mask, prev_mask);
                stop_run();
            end
            assert (out_data == prev_data) else begin
                $display("[FAIL] out_data got %h expected %h", out_data, prev_data);
                stop_run();
            end
        end
        if (out_valid && out_ready) begin
            for (int o = 0; o < N_PORTS; o++) begin
                if (out_mask[o]) begin
                    src = int'(out_data[o][DATA_W-1 -: PORT_W]);
                    q = src*N_PORTS + o;
                    assert (exp_q[q].size() > 0) else begin
                        $display("Word %h on output %0d has no pending flit", out_data[o], o);
                        stop_run();
                    end
                    assert (out_data[o] == exp_q[q][0]) else begin
                        $display("[FAIL] out_data[%0d] got %h expected %h", o, out_data[o],
                                 exp_q[q][0]);
                        stop_run();
                    end
                    void'(exp_q[q].pop_front());
                    // Ports 0 and 2 share output 3 and must take turns
                    if (o == 3 && (src == 0 || src == 2)) begin
                        assert (!(src == last_rr_src && other_busy)) else begin
                            $display("Output 3 served port %0d twice while port %0d waited",
                                     src, 2 - src);
                            stop_run();
                        end
                        last_rr_src = src;
                        other_busy  = exp_q[(2 - src)*N_PORTS + 3].size() > 0;
                    end
                end else begin
                    assert (out_data[o] == '0) else begin
                        $display("[FAIL] out_data[%0d] got %h expected 00", o, out_data[o]);
                        stop_run();
                    end
                end
            end
        end
        prev_valid = out_valid;
        prev_ready = out_ready;
        prev_mask  = out_mask;
        prev_data  = out_data;
    endtask

    always @(posedge clk) begin
        if (running) begin
            cyc++;
            drive_ports(cyc >= HOLD_START && cyc < HOLD_END);
            check_egress();
            if (cyc == HOLD_END) begin
                assert (ready_dropped) else begin
                    $display("No ingress queue filled while the egress was held");
                    stop_run();
                end
            end
            if (cyc >= HOLD_START - 1 && cyc < HOLD_END - 1) begin
                out_ready <= 1'b0;
            end else begin
                out_ready <= ($urandom % 4) != 0;
            end
        end
    end

    initial begin
        clk         = 0;
        rst_n       = 0;
        in_valid    = '0;
        in_dest     = '0;
        in_data     = '0;
        out_ready   = 0;
        running     = 0;
        loaded      = 0;
        cyc         = 0;
        last_rr_src = -1;
        other_busy  = 0;
        prev_valid  = 0;
        prev_ready  = 0;
        void'($urandom(6));
        load_patterns();
        loaded = 1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!out_valid && out_mask == '0) else begin
            $display("[FAIL] out_valid %h out_mask %h after reset, expected 0 and 0",
                     out_valid, out_mask);
            stop_run();
        end
        assert (in_ready == '1) else begin
            $display("[FAIL] in_ready got %h expected %h after reset", in_ready, 4'hf);
            stop_run();
        end
        running = 1;
        while (!(all_sent() && cyc > HOLD_END)) begin
            @(negedge clk);
        end
        // Queues and crossbar empty out after the last push
        drain_cyc = 0;
        while (pending_total() != 0 && drain_cyc < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cyc++;
        end
        repeat (3) @(negedge clk);
        for (int q = 0; q < N_PORTS*N_PORTS; q++) begin
            assert (exp_q[q].size() == 0) else begin
                $display("Flits from port %0d to port %0d were never delivered",
                         q / N_PORTS, q % N_PORTS);
                stop_run();
            end
        end
        $display("All tests passed!");
        $finish;
    end

    // Watchdog scaled to the pattern count
    initial begin
        wait (loaded);
        repeat (RESET_CYCLES + 40*n_lines) @(posedge clk);
        $display("Watchdog expired after %0d cycles", RESET_CYCLES + 40*n_lines);
        stop_run();
    end

endmodule

//--- switch_patterns.txt
# ingress_port destination data_hex gap_cycles
# data bits 7:6 equal the ingress port, every data byte is unique
0 3 01 0
0 3 02 0
0 3 03 0
0 3 04 0
2 3 81 0
2 3 82 0
2 3 83 0
2 3 84 0
1 0 41 1
1 2 42 2
1 0 43 0
1 1 44 3
1 2 45 0
3 0 c1 12
3 1 c2 12
3 2 c3 12
3 0 c4 0
3 1 c5 0
3 2 c6 0
3 0 c7 0
3 1 c8 0
3 2 c9 0
3 0 ca 0
3 1 cb 0

//--- sim.f
switch_cfg_pkg.sv
switch_types_pkg.sv
ingress_fifo.sv
output_arbiter.sv
crossbar_pipe.sv
switch_top.sv
tb_switch.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_switch -o sim_switch \
    && ./obj_dir/sim_switch > sim.log 2>&1
cat sim.log
grep -q "All tests passed!" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
